// ==== verilog/cpu_pkg.sv ====
// ==========================================================================
// Shared types and constants for the RV32I-subset pipeline.
// Both memories hold 64 words, indexed by byte address bits 7:2, and wrap.
// The UART runs 8N1 at CLKS_PER_BIT clocks per bit.
// ==========================================================================
package cpu_pkg;

  localparam int XLEN         = 32;
  localparam int NUM_REGS     = 32;
  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 64;
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  typedef logic [XLEN-1:0]                 word_t;
  typedef logic [4:0]                      reg_addr_t;
  typedef logic [$clog2(IMEM_WORDS)-1:0]   imem_addr_t;
  typedef logic [$clog2(DMEM_WORDS)-1:0]   dmem_addr_t;
  typedef logic [7:0]                      byte_t;
  typedef logic [BAUD_CNT_W-1:0]           baud_cnt_t;
  typedef logic [2:0]                      bit_idx_t;
  typedef logic [1:0]                      byte_sel_t;
  typedef logic [6:0]                      opcode_t;
  typedef logic [2:0]                      funct3_t;
  typedef logic [6:0]                      funct7_t;

  localparam opcode_t OPC_REG    = 7'b0110011;
  localparam opcode_t OPC_IMM    = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_WORD    = 3'b010;
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  localparam funct7_t F7_BASE    = 7'b0000000;
  localparam funct7_t F7_SUB     = 7'b0100000;

  // ALU_ADD is zero so a cleared ctrl is a harmless add
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // reg_write is already low for rd x0 and for bubbles
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     data1;
    word_t     data2;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     store_data;
    word_t     alu_result;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     load_data;
    word_t     alu_result;
  } mem_wb_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
// ==========================================================================
// 8N1 receiver. The line passes a two-flop synchronizer first, so the
// byte strobe lags the wire by two clocks. A low stop bit drops the byte.
// ==========================================================================
module uart_rx (
  input  logic           clk,
  input  logic           rst,
  input  logic           serial,
  output logic           byte_valid,
  output cpu_pkg::byte_t data
);
  import cpu_pkg::*;

  rx_state_e  state;
  baud_cnt_t  baud_cnt;
  bit_idx_t   bit_idx;
  logic [1:0] serial_sync;
  logic       rx_bit;
  logic       half_bit;
  logic       full_bit;

  assign rx_bit   = serial_sync[1];
  assign half_bit = baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
  assign full_bit = baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= RX_IDLE;
      baud_cnt    <= '0;
      bit_idx     <= '0;
      serial_sync <= 2'b11;
      byte_valid  <= 1'b0;
    end else begin
      serial_sync <= {serial_sync[0], serial};
      byte_valid  <= 1'b0;
      baud_cnt    <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (!rx_bit) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (half_bit) begin
            // Start bit gone at mid-bit means a glitch
            baud_cnt <= '0;
            state    <= rx_bit ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (&bit_idx) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (full_bit) begin
            byte_valid <= rx_bit;
            state      <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && full_bit) begin
      data <= {rx_bit, data[7:1]};
    end
  end

  a_single_strobe: assert property (@(posedge clk) disable iff (rst)
    byte_valid |=> !byte_valid);

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
// ==========================================================================
// PC, instruction memory and UART loader. While flash is high the pc
// sits at 0, fetch shows bubbles and bytes fill memory little-endian from
// word 0. Instruction memory is read combinationally and has no reset.
// ==========================================================================
module fetch_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            flash,
  input  logic            byte_valid,
  input  cpu_pkg::byte_t  rx_byte,
  input  logic            pc_write,
  input  logic            pc_src,
  input  cpu_pkg::word_t  pc_branch,
  output cpu_pkg::if_id_t if_id
);
  import cpu_pkg::*;

  word_t      imem [IMEM_WORDS];
  word_t      pc;
  word_t      load_word;
  byte_sel_t  byte_cnt;
  imem_addr_t load_idx;
  logic       load_ready;
  logic       flash_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt   <= '0;
      load_idx   <= '0;
      load_ready <= 1'b0;
      flash_q    <= 1'b0;
    end else begin
      flash_q    <= flash;
      load_ready <= 1'b0;
      if (load_ready) begin
        load_idx <= load_idx + 1'b1;
      end
      if (flash && !flash_q) begin
        byte_cnt <= '0;
        load_idx <= '0;
      end else if (flash && byte_valid) begin
        byte_cnt   <= byte_cnt + 1'b1;
        load_ready <= &byte_cnt;
      end
    end
  end

  // Word assembly and the write one cycle after the fourth byte
  always_ff @(posedge clk) begin
    if (flash && byte_valid) begin
      load_word <= {rx_byte, load_word[XLEN-1:8]};
    end
    if (load_ready) begin
      imem[load_idx] <= load_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (flash) begin
      pc <= '0;
    end else if (pc_write) begin
      pc <= pc_src ? pc_branch : pc + 32'd4;
    end
  end

  always_comb begin
    if_id.pc    = pc;
    if_id.instr = flash ? '0 : imem[imem_addr_t'(pc[XLEN-1:2])];
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
// ==========================================================================
// Register file, control decode, immediates, hazard stall and early
// branch resolution. Unsupported encodings become bubbles. Branches take
// operands from EX/MEM or writeback and cost one bubble when taken.
// ==========================================================================
module decode_stage (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::if_id_t  if_id,
  input  cpu_pkg::retire_t wb,
  input  cpu_pkg::id_ex_t  id_ex_q,
  input  cpu_pkg::ex_mem_t ex_mem_q,
  output cpu_pkg::id_ex_t  id_ex_d,
  output cpu_pkg::word_t   pc_branch,
  output logic             pc_write,
  output logic             fetch_write,
  output logic             pc_src,
  output logic             if_flush
);
  import cpu_pkg::*;

  word_t     regs [NUM_REGS];
  word_t     instr;
  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  ctrl_t     ctrl;
  word_t     imm;
  logic      is_branch;
  logic      uses_rs1;
  logic      uses_rs2;
  word_t     rf_data1;
  word_t     rf_data2;
  word_t     cmp_a;
  word_t     cmp_b;
  logic      load_use;
  logic      branch_hazard;
  logic      stall;
  logic      taken;

  // Writeback passes straight through to a same-cycle read
  function automatic word_t read_reg(reg_addr_t a);
    if (a == '0) return '0;
    if (wb.valid && wb.rd == a) return wb.data;
    return regs[a];
  endfunction

  function automatic word_t fwd_branch(reg_addr_t a, word_t rf_val);
    if (ex_mem_q.ctrl.reg_write && !ex_mem_q.ctrl.mem_read && ex_mem_q.rd == a) begin
      return ex_mem_q.alu_result;
    end
    return rf_val;
  endfunction

  assign instr  = if_id.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    ctrl      = '0;
    imm       = {{20{instr[31]}}, instr[31:20]};
    is_branch = 1'b0;
    uses_rs1  = 1'b1;
    uses_rs2  = 1'b0;
    case (opcode)
      OPC_REG: begin
        uses_rs2       = 1'b1;
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  ctrl.alu_op = ALU_SUB;
          {F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}:     ctrl.alu_op = ALU_XOR;
          {F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
          default:               ctrl.reg_write = 1'b0;
        endcase
      end
      OPC_IMM: begin
        ctrl.reg_write = funct3 == F3_ADD_SUB;
        ctrl.alu_src   = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.reg_write  = funct3 == F3_WORD;
        ctrl.mem_read   = funct3 == F3_WORD;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      OPC_STORE: begin
        imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        uses_rs2       = 1'b1;
        ctrl.mem_write = funct3 == F3_WORD;
        ctrl.alu_src   = 1'b1;
      end
      OPC_BRANCH: begin
        imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        uses_rs2  = 1'b1;
        is_branch = funct3 == F3_BEQ || funct3 == F3_BNE;
      end
      default: uses_rs1 = 1'b0;
    endcase
    if (rd == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

  assign load_use = id_ex_q.ctrl.mem_read && id_ex_q.ctrl.reg_write &&
                    ((uses_rs1 && id_ex_q.rd == rs1) || (uses_rs2 && id_ex_q.rd == rs2));
  // Branch operands must be ready by the end of this cycle
  assign branch_hazard = is_branch &&
      ((id_ex_q.ctrl.reg_write && (id_ex_q.rd == rs1 || id_ex_q.rd == rs2)) ||
       (ex_mem_q.ctrl.reg_write && ex_mem_q.ctrl.mem_read &&
        (ex_mem_q.rd == rs1 || ex_mem_q.rd == rs2)));
  assign stall = load_use || branch_hazard;

  assign rf_data1 = read_reg(rs1);
  assign rf_data2 = read_reg(rs2);
  assign cmp_a    = fwd_branch(rs1, rf_data1);
  assign cmp_b    = fwd_branch(rs2, rf_data2);
  assign taken    = is_branch && ((funct3 == F3_BNE) ? cmp_a != cmp_b : cmp_a == cmp_b);

  assign pc_write    = !stall;
  assign fetch_write = !stall;
  assign pc_src      = taken && !stall;
  assign if_flush    = pc_src;
  assign pc_branch   = if_id.pc + imm;

  always_comb begin
    id_ex_d.ctrl  = ctrl;
    id_ex_d.data1 = rf_data1;
    id_ex_d.data2 = rf_data2;
    id_ex_d.imm   = imm;
    id_ex_d.rs1   = rs1;
    id_ex_d.rs2   = rs2;
    id_ex_d.rd    = rd;
  end

  a_no_stall_flush: assert property (@(posedge clk) disable iff (rst) !(stall && if_flush));

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
// ==========================================================================
// Operand forwarding and ALU, purely combinational. A load in EX/MEM is
// never forwarded; decode stalls so its user sees it from writeback.
// ==========================================================================
module execute_stage (
  input  cpu_pkg::id_ex_t  id_ex,
  input  cpu_pkg::ex_mem_t ex_mem_fwd,
  input  cpu_pkg::retire_t wb_fwd,
  output cpu_pkg::ex_mem_t ex_mem_d
);
  import cpu_pkg::*;

  word_t op_a;
  word_t fwd_b;
  word_t op_b;
  word_t result;

  // Nearest older writer wins
  function automatic word_t forward(reg_addr_t src, word_t id_val);
    if (ex_mem_fwd.ctrl.reg_write && !ex_mem_fwd.ctrl.mem_read && ex_mem_fwd.rd == src) begin
      return ex_mem_fwd.alu_result;
    end
    if (wb_fwd.valid && wb_fwd.rd == src) begin
      return wb_fwd.data;
    end
    return id_val;
  endfunction

  assign op_a  = forward(id_ex.rs1, id_ex.data1);
  assign fwd_b = forward(id_ex.rs2, id_ex.data2);
  assign op_b  = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
      default: result = op_a + op_b;
    endcase
  end

  always_comb begin
    ex_mem_d.ctrl       = id_ex.ctrl;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.store_data = fwd_b;
    ex_mem_d.alu_result = result;
  end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps
// ==========================================================================
// 64-word data memory, word accesses only. Addresses wrap at 256 bytes
// and the low two address bits are ignored.
// ==========================================================================
module memory_stage (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::ex_mem_t ex_mem,
  output cpu_pkg::mem_wb_t mem_wb_d
);
  import cpu_pkg::*;

  word_t      dmem [DMEM_WORDS];
  dmem_addr_t addr;

  assign addr = dmem_addr_t'(ex_mem.alu_result[XLEN-1:2]);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.ctrl.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  always_comb begin
    mem_wb_d.ctrl       = ex_mem.ctrl;
    mem_wb_d.rd         = ex_mem.rd;
    mem_wb_d.load_data  = ex_mem.ctrl.mem_read ? dmem[addr] : '0;
    mem_wb_d.alu_result = ex_mem.alu_result;
  end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
// ==========================================================================
// Five-stage RV32I-subset core with UART program load. Hold flash high
// to load, then drop it to run from pc 0. Each register write shows on
// retire for one cycle, in program order.
// ==========================================================================
module cpu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             uart_serial,
  input  logic             flash,
  output cpu_pkg::retire_t retire
);
  import cpu_pkg::*;

  if_id_t  if_id_d;
  if_id_t  if_id_q;
  id_ex_t  id_ex_d;
  id_ex_t  id_ex_q;
  ex_mem_t ex_mem_d;
  ex_mem_t ex_mem_q;
  mem_wb_t mem_wb_d;
  mem_wb_t mem_wb_q;
  word_t   wb_data;
  word_t   pc_branch;
  byte_t   rx_byte;
  logic    byte_valid;
  logic    pc_write;
  logic    fetch_write;
  logic    pc_src;
  logic    if_flush;

  // Writeback select
  always_comb begin
    wb_data      = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    retire.valid = mem_wb_q.ctrl.reg_write;
    retire.rd    = mem_wb_q.rd;
    retire.data  = wb_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_id_q  <= '0;
      id_ex_q  <= '0;
      ex_mem_q <= '0;
      mem_wb_q <= '0;
    end else begin
      if (if_flush) begin
        if_id_q.pc    <= if_id_d.pc;
        if_id_q.instr <= '0;
      end else if (fetch_write) begin
        if_id_q <= if_id_d;
      end
      id_ex_q <= id_ex_d;
      // Stall inserts a bubble behind the held instruction
      if (!fetch_write) begin
        id_ex_q.ctrl <= '0;
      end
      ex_mem_q <= ex_mem_d;
      mem_wb_q <= mem_wb_d;
    end
  end

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst        (rst),
    .serial     (uart_serial),
    .byte_valid (byte_valid),
    .data       (rx_byte)
  );

  fetch_stage i_fetch_stage (
    .clk        (clk),
    .rst        (rst),
    .flash      (flash),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte),
    .pc_write   (pc_write),
    .pc_src     (pc_src),
    .pc_branch  (pc_branch),
    .if_id      (if_id_d)
  );

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst         (rst),
    .if_id       (if_id_q),
    .wb          (retire),
    .id_ex_q     (id_ex_q),
    .ex_mem_q    (ex_mem_q),
    .id_ex_d     (id_ex_d),
    .pc_branch   (pc_branch),
    .pc_write    (pc_write),
    .fetch_write (fetch_write),
    .pc_src      (pc_src),
    .if_flush    (if_flush)
  );

  execute_stage i_execute_stage (
    .id_ex      (id_ex_q),
    .ex_mem_fwd (ex_mem_q),
    .wb_fwd     (retire),
    .ex_mem_d   (ex_mem_d)
  );

  memory_stage i_memory_stage (
    .clk      (clk),
    .rst      (rst),
    .ex_mem   (ex_mem_q),
    .mem_wb_d (mem_wb_d)
  );

  a_no_x0_retire: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.rd != '0);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
// ==========================================================================
// Free-running testbench clock with a 10 ns period. It starts low.
// ==========================================================================
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
// ==========================================================================
// Random 40-word program in x0..x7, loaded over UART, then checked
// retire by retire against an ISA model. Branches only jump forward,
// so every run ends at the closing self-loop.
// ==========================================================================
module cpu_tb;
  import cpu_pkg::*;

  localparam int PROG_LEN = 40;

  typedef struct packed {
    opcode_t   opc;
    funct3_t   f3;
    funct7_t   f7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
  } instr_fields_t;

  logic          clk;
  logic          rst;
  logic          uart_serial;
  logic          flash;
  retire_t       retire;
  logic [31:0]   rng_state;
  instr_fields_t prog [PROG_LEN];
  word_t         code [PROG_LEN];
  retire_t       expected [$];

  tb_clock i_tb_clock (
    .clk (clk)
  );

  cpu_top i_cpu_top (
    .clk         (clk),
    .rst         (rst),
    .uart_serial (uart_serial),
    .flash       (flash),
    .retire      (retire)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = xorshift32(rng_state);
    return rng_state % n;
  endfunction

  function automatic instr_fields_t random_instr(input int idx);
    instr_fields_t f;
    int unsigned   kind;
    int unsigned   span;
    logic [11:0]   imm12;
    f     = '0;
    f.rd  = reg_addr_t'(rand_below(8));
    f.rs1 = reg_addr_t'(rand_below(8));
    f.rs2 = reg_addr_t'(rand_below(8));
    kind  = rand_below(16);
    if (kind < 7) begin
      f.opc = OPC_REG;
      case (rand_below(6))
        0: f.f3 = F3_ADD_SUB;
        1: begin
          f.f3 = F3_ADD_SUB;
          f.f7 = F7_SUB;
        end
        2: f.f3 = F3_SLT;
        3: f.f3 = F3_XOR;
        4: f.f3 = F3_OR;
        default: f.f3 = F3_AND;
      endcase
    end else if (kind < 10) begin
      imm12 = 12'(rand_below(4096));
      f.opc = OPC_IMM;
      f.f3  = F3_ADD_SUB;
      f.imm = {{20{imm12[11]}}, imm12};
    end else if (kind < 14) begin
      // Small window off x0 so loads often return earlier stores
      f.opc = (kind < 12) ? OPC_LOAD : OPC_STORE;
      f.f3  = F3_WORD;
      f.rs1 = '0;
      f.imm = word_t'(4 * rand_below(8));
    end else begin
      // Short forward hop, never past the self-loop
      span  = PROG_LEN - 1 - idx;
      if (span > 4) begin
        span = 4;
      end
      f.opc = OPC_BRANCH;
      f.rd  = '0;
      f.f3  = rand_below(2) ? F3_BNE : F3_BEQ;
      f.imm = word_t'(4 * (1 + rand_below(span)));
    end
    return f;
  endfunction

  function automatic word_t encode_instr(input instr_fields_t f);
    case (f.opc)
      OPC_REG:    return {f.f7, f.rs2, f.rs1, f.f3, f.rd, f.opc};
      OPC_STORE:  return {f.imm[11:5], f.rs2, f.rs1, f.f3, f.imm[4:0], f.opc};
      OPC_BRANCH: return {f.imm[12], f.imm[10:5], f.rs2, f.rs1, f.f3,
                          f.imm[4:1], f.imm[11], f.opc};
      default:    return {f.imm[11:0], f.rs1, f.f3, f.rd, f.opc};
    endcase
  endfunction

  // ISA model, one instruction at a time
  task automatic build_expected();
    word_t         mregs [NUM_REGS];
    word_t         mmem [DMEM_WORDS];
    word_t         a;
    word_t         b;
    word_t         res;
    word_t         ea;
    logic          writes;
    retire_t       r;
    instr_fields_t f;
    int            pc;
    int            next;
    foreach (mregs[i]) mregs[i] = '0;
    foreach (mmem[i]) mmem[i] = '0;
    pc = 0;
    while (pc < PROG_LEN - 1) begin
      f      = prog[pc];
      a      = mregs[f.rs1];
      b      = mregs[f.rs2];
      ea     = a + f.imm;
      res    = '0;
      writes = 1'b0;
      next   = pc + 1;
      case (f.opc)
        OPC_REG: begin
          writes = 1'b1;
          case (f.f3)
            F3_ADD_SUB: res = (f.f7 == F7_SUB) ? a - b : a + b;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_OR:      res = a | b;
            default:    res = a & b;
          endcase
        end
        OPC_IMM: begin
          writes = 1'b1;
          res    = ea;
        end
        OPC_LOAD: begin
          writes = 1'b1;
          res    = mmem[ea[7:2]];
        end
        OPC_STORE: mmem[ea[7:2]] = b;
        default: begin
          if ((f.f3 == F3_BNE) ? (a != b) : (a == b)) begin
            next = pc + int'(f.imm >> 2);
          end
        end
      endcase
      if (writes && f.rd != '0) begin
        mregs[f.rd] = res;
        r.valid     = 1'b1;
        r.rd        = f.rd;
        r.data      = res;
        expected.push_back(r);
      end
      pc = next;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got.rd !== exp.rd) begin
      report_failure($sformatf("mismatch at %0t: retire.rd got x%0d, expected x%0d",
                               $time, got.rd, exp.rd));
    end else if (got.data !== exp.data) begin
      report_failure($sformatf("mismatch at %0t: retire.data (x%0d) got %h, expected %h",
                               $time, got.rd, got.data, exp.data));
    end
  endtask

  task automatic drive_bit(input logic value);
    @(posedge clk);
    uart_serial <= value;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // 8N1 frame, then wait for the receiver strobe during the stop bit
  task automatic send_byte(input byte_t value);
    logic seen;
    int   waited;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(value[i]);
    end
    @(posedge clk);
    uart_serial <= 1'b1;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < 2 * CLKS_PER_BIT) begin
      @(negedge clk);
      seen   = i_cpu_top.byte_valid;
      waited = waited + 1;
    end
    if (!seen) begin
      report_failure($sformatf("UART byte %h was never received by the DUT", value));
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic collect_retires();
    int idx;
    int cycles;
    idx    = 0;
    cycles = 0;
    while (idx < expected.size() && cycles < 1000) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (retire.valid) begin
        check_retire(retire, expected[idx]);
        idx = idx + 1;
      end
    end
    if (idx < expected.size()) begin
      report_failure($sformatf("Timed out with %0d of %0d retirements seen",
                               idx, expected.size()));
    end
  endtask

  task automatic check_idle();
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      if (retire.valid) begin
        report_failure($sformatf("Extra retirement to x%0d after the final self-loop",
                                 retire.rd));
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    flash       = 1'b0;
    uart_serial = 1'b1;
    rng_state   = 32'h7f3a_317d;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      prog[i] = random_instr(i);
    end
    // beq x0, x0, 0
    prog[PROG_LEN-1]     = '0;
    prog[PROG_LEN-1].opc = OPC_BRANCH;
    prog[PROG_LEN-1].f3  = F3_BEQ;
    for (int i = 0; i < PROG_LEN; i++) begin
      code[i] = encode_instr(prog[i]);
    end
    build_expected();
    $display("Program of %0d words, %0d retirements expected", PROG_LEN, expected.size());

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    flash <= 1'b1;
    repeat (4) @(posedge clk);
    for (int w = 0; w < PROG_LEN; w++) begin
      for (int b = 0; b < 4; b++) begin
        send_byte(code[w][8*b +: 8]);
      end
    end
    @(posedge clk);
    flash <= 1'b0;

    collect_retires();
    check_idle();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/cpu_pkg.sv
verilog/uart_rx.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_top.sv
verification/tb_clock.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator.
# The exit status is nonzero when the simulation ends in $fatal.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module cpu_tb -o cpu_tb

./obj_dir/cpu_tb
